//--- Bender.yml
package:
  name: rvCore

sources:
  - common/rvPkg.sv
  - core/instrDecode.sv
  - core/aluUnit.sv
  - core/regFile.sv
  - core/loadStoreUnit.sv
  - core/coreControl.sv
  - verilog/rvCore.sv
  - target: test
    files:
      - tests/wbMemModel.sv
      - tests/storeMonitor.sv
      - tests/rvCore_checker.sv
      - tests/tbRvCore.sv

//--- build.f
common/rvPkg.sv
core/instrDecode.sv
core/aluUnit.sv
core/regFile.sv
core/loadStoreUnit.sv
core/coreControl.sv
verilog/rvCore.sv
tests/wbMemModel.sv
tests/storeMonitor.sv
tests/rvCore_checker.sv
tests/tbRvCore.sv

//--- common/rvPkg.sv
package rvPkg;

	localparam int xlen = 32;
	localparam logic [xlen-1:0] resetPc = 32'h0000_0000;

	// RV32I major opcodes
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opAuipc  = 7'b0010111;
	localparam logic [6:0] opReg    = 7'b0110011;
	localparam logic [6:0] opImm    = 7'b0010011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opJalr   = 7'b1100111;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor,
		aluSll, aluSrl, aluSra, aluSlt, aluSltu
	} aluOp_e;

	typedef enum logic [2:0] {
		brNone, brEq, brNe, brLt, brGe
	} branchOp_e;

	typedef enum logic [2:0] {
		ldNone, ldWord, ldHalf, ldByte, ldHalfU, ldByteU
	} loadOp_e;

	typedef enum logic [1:0] {
		stNone, stWord, stHalf, stByte
	} storeOp_e;

	typedef enum logic [1:0] {
		wbAlu, wbMemory, wbPcPlus4, wbCompare
	} wbSel_e;

	typedef enum logic [1:0] {
		aReg, aPc, aZero
	} aSel_e;

	typedef enum logic {
		bReg, bImm
	} bSel_e;

	typedef struct packed {
		logic      regWrite;
		wbSel_e    wbSel;
		aSel_e     aSel;
		bSel_e     bSel;
		aluOp_e    aluOp;
		branchOp_e branchOp;
		logic      isJal;
		logic      isJalr;
		loadOp_e   loadOp;
		storeOp_e  storeOp;
	} ctrl_t;

	// Wishbone master to slave
	typedef struct packed {
		logic [xlen-1:0] adr;
		logic [xlen-1:0] datW;
		logic [3:0]      sel;
		logic            we;
		logic            cyc;
		logic            stb;
	} wbReq_t;

	// Wishbone slave to master
	typedef struct packed {
		logic [xlen-1:0] datR;
		logic            ack;
	} wbRsp_t;

endpackage

//--- core/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
	input  rvPkg::ctrl_t           ctrl,
	input  logic [rvPkg::xlen-1:0] opA,
	input  logic [rvPkg::xlen-1:0] opB,
	output logic [rvPkg::xlen-1:0] result,
	output logic                   eq,
	output logic                   lt
);

	logic [4:0] shamt;
	logic       signedLt;
	logic       unsignedLt;

	assign shamt      = opB[4:0];
	assign signedLt   = $signed(opA) < $signed(opB);
	assign unsignedLt = opA < opB;

	assign eq = (opA == opB);
	assign lt = (ctrl.aluOp == rvPkg::aluSltu) ? unsignedLt : signedLt;  // BLTU/BGEU pick sltu

	always_comb
	begin
		case (ctrl.aluOp)
			rvPkg::aluAdd:  result = opA + opB;
			rvPkg::aluSub:  result = opA - opB;
			rvPkg::aluAnd:  result = opA & opB;
			rvPkg::aluOr:   result = opA | opB;
			rvPkg::aluXor:  result = opA ^ opB;
			rvPkg::aluSll:  result = opA << shamt;
			rvPkg::aluSrl:  result = opA >> shamt;
			rvPkg::aluSra:  result = $signed(opA) >>> shamt;
			rvPkg::aluSlt:  result = {{(rvPkg::xlen-1){1'b0}}, signedLt};
			rvPkg::aluSltu: result = {{(rvPkg::xlen-1){1'b0}}, unsignedLt};
			default:        result = opA + opB;
		endcase
	end

endmodule

//--- core/coreControl.sv
`timescale 1ns/1ps

module coreControl (
	input  logic                   clk,
	input  logic                   rstN,
	input  rvPkg::ctrl_t           ctrl,
	input  logic [rvPkg::xlen-1:0] imm,
	input  logic                   eq,
	input  logic                   lt,
	input  logic [rvPkg::xlen-1:0] aluResult,
	input  logic [rvPkg::xlen-1:0] rData1,
	input  logic [rvPkg::xlen-1:0] rData2,
	input  logic [3:0]             lsuSel,
	input  logic [rvPkg::xlen-1:0] storeData,
	input  logic [rvPkg::xlen-1:0] loadValue,
	output logic [rvPkg::xlen-1:0] instr,
	output logic [rvPkg::xlen-1:0] opA,
	output logic [rvPkg::xlen-1:0] opB,
	output logic                   regWe,
	output logic [rvPkg::xlen-1:0] wData,
	output rvPkg::wbReq_t          wbReq,
	input  rvPkg::wbRsp_t          wbRsp
);

	typedef enum logic [2:0] {
		stateFetch,
		stateDecode,
		stateExecute,
		stateMemory,
		stateWriteback
	} state_e;

	state_e                 state;
	logic [rvPkg::xlen-1:0] pc;
	logic [rvPkg::xlen-1:0] pcPlus4;
	logic [rvPkg::xlen-1:0] nextPc;
	logic [rvPkg::xlen-1:0] aluOut;
	logic [rvPkg::xlen-1:0] memData;
	logic                   eqFlag;
	logic                   ltFlag;
	logic                   takeBranch;
	logic                   memAccess;
	logic                   busActive;
	logic                   busWe;
	logic [rvPkg::xlen-1:0] busAdr;
	logic [rvPkg::xlen-1:0] busDat;
	logic [3:0]             busSel;

	assign pcPlus4   = pc + 32'd4;
	assign memAccess = (ctrl.loadOp != rvPkg::ldNone) || (ctrl.storeOp != rvPkg::stNone);
	assign regWe     = (state == stateWriteback) && ctrl.regWrite;
	assign wbReq     = '{adr: busAdr, datW: busDat, sel: busSel, we: busWe,
		cyc: busActive, stb: busActive};

	always_comb
	begin
		case (ctrl.branchOp)
			rvPkg::brEq: takeBranch = eqFlag;
			rvPkg::brNe: takeBranch = !eqFlag;
			rvPkg::brLt: takeBranch = ltFlag;
			rvPkg::brGe: takeBranch = !ltFlag;
			default:     takeBranch = 1'b0;
		endcase
	end

	always_comb
	begin
		if (ctrl.isJalr)
			nextPc = {aluOut[rvPkg::xlen-1:1], 1'b0};   // rs1 + imm, bit 0 cleared
		else if (ctrl.isJal || takeBranch)
			nextPc = pc + imm;
		else
			nextPc = pcPlus4;
	end

	always_comb
	begin
		case (ctrl.wbSel)
			rvPkg::wbMemory:  wData = memData;
			rvPkg::wbPcPlus4: wData = pcPlus4;          // Link value
			rvPkg::wbCompare: wData = {{(rvPkg::xlen-1){1'b0}}, ltFlag};
			default:          wData = aluOut;
		endcase
	end

	// Sequencing and bus handshake
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state     <= stateFetch;
			pc        <= rvPkg::resetPc;
			busActive <= 1'b0;
			busWe     <= 1'b0;
		end
		else
		begin
			case (state)
				stateFetch:
				begin
					if (!busActive)
						busActive <= 1'b1;                   // Only after reset
					else if (wbRsp.ack)
					begin
						busActive <= 1'b0;
						state     <= stateDecode;
					end
				end
				stateDecode:
					state <= stateExecute;
				stateExecute:
				begin
					if (memAccess)
					begin
						busActive <= 1'b1;
						busWe     <= (ctrl.storeOp != rvPkg::stNone);
						state     <= stateMemory;
					end
					else
						state <= stateWriteback;
				end
				stateMemory:
				begin
					if (wbRsp.ack)
					begin
						busActive <= 1'b0;
						busWe     <= 1'b0;
						state     <= stateWriteback;
					end
				end
				stateWriteback:
				begin
					pc        <= nextPc;
					busActive <= 1'b1;                     // Next fetch starts here
					state     <= stateFetch;
				end
				default:
					state <= stateFetch;
			endcase
		end
	end

	// Instruction, operand and bus payload registers
	always_ff @(posedge clk)
	begin
		case (state)
			stateFetch:
			begin
				if (!busActive)
				begin
					busAdr <= pc;
					busSel <= 4'b1111;
				end
				else if (wbRsp.ack)
					instr <= wbRsp.datR;
			end
			stateDecode:
			begin
				case (ctrl.aSel)
					rvPkg::aPc:   opA <= pc;
					rvPkg::aZero: opA <= '0;
					default:      opA <= rData1;
				endcase
				opB <= (ctrl.bSel == rvPkg::bReg) ? rData2 : imm;
			end
			stateExecute:
			begin
				aluOut <= aluResult;
				eqFlag <= eq;
				ltFlag <= lt;
				busAdr <= aluResult;                     // Bus idle, harmless without access
				busSel <= lsuSel;
				busDat <= storeData;
			end
			stateMemory:
			begin
				if (wbRsp.ack)
					memData <= loadValue;
			end
			default:
			begin
				busAdr <= nextPc;
				busSel <= 4'b1111;
			end
		endcase
	end

endmodule

//--- core/instrDecode.sv
`timescale 1ns/1ps

module instrDecode (
	input  logic [rvPkg::xlen-1:0] instr,
	output rvPkg::ctrl_t           ctrl,
	output logic [rvPkg::xlen-1:0] imm
);

	logic [6:0]             opcode;
	logic [2:0]             funct3;
	logic                   bit30;
	logic [rvPkg::xlen-1:0] immU;
	logic [rvPkg::xlen-1:0] immI;
	logic [rvPkg::xlen-1:0] immS;
	logic [rvPkg::xlen-1:0] immB;
	logic [rvPkg::xlen-1:0] immJ;
	logic [rvPkg::xlen-1:0] immShift;

	// Shared by R-type and I-type, alt picks SUB or SRA
	function automatic rvPkg::aluOp_e aluFromFunct3(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? rvPkg::aluSub : rvPkg::aluAdd;
			3'b001:  return rvPkg::aluSll;
			3'b010:  return rvPkg::aluSlt;
			3'b011:  return rvPkg::aluSltu;
			3'b100:  return rvPkg::aluXor;
			3'b101:  return alt ? rvPkg::aluSra : rvPkg::aluSrl;
			3'b110:  return rvPkg::aluOr;
			default: return rvPkg::aluAnd;
		endcase
	endfunction

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign bit30  = instr[30];

	assign immU     = {instr[31:12], 12'b0};
	assign immI     = {{20{instr[31]}}, instr[31:20]};
	assign immS     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB     = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immJ     = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
	assign immShift = {27'b0, instr[24:20]};         // shamt only

	always_comb
	begin
		ctrl.regWrite = 1'b0;                          // Unknown opcode is a no-op
		ctrl.wbSel    = rvPkg::wbAlu;
		ctrl.aSel     = rvPkg::aReg;
		ctrl.bSel     = rvPkg::bImm;
		ctrl.aluOp    = rvPkg::aluAdd;
		ctrl.branchOp = rvPkg::brNone;
		ctrl.isJal    = 1'b0;
		ctrl.isJalr   = 1'b0;
		ctrl.loadOp   = rvPkg::ldNone;
		ctrl.storeOp  = rvPkg::stNone;
		imm           = immI;

		case (opcode)
			rvPkg::opLoad:
			begin
				ctrl.wbSel    = rvPkg::wbMemory;
				ctrl.regWrite = !(funct3 == 3'b011 || funct3[2:1] == 2'b11);
				case (funct3)
					3'b000:  ctrl.loadOp = rvPkg::ldByte;
					3'b001:  ctrl.loadOp = rvPkg::ldHalf;
					3'b010:  ctrl.loadOp = rvPkg::ldWord;
					3'b100:  ctrl.loadOp = rvPkg::ldByteU;
					3'b101:  ctrl.loadOp = rvPkg::ldHalfU;
					default: ctrl.loadOp = rvPkg::ldNone;
				endcase
			end
			rvPkg::opStore:
			begin
				imm = immS;
				case (funct3)
					3'b000:  ctrl.storeOp = rvPkg::stByte;
					3'b001:  ctrl.storeOp = rvPkg::stHalf;
					3'b010:  ctrl.storeOp = rvPkg::stWord;
					default: ctrl.storeOp = rvPkg::stNone;
				endcase
			end
			rvPkg::opLui:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.aSel     = rvPkg::aZero;              // 0 + immU
				imm           = immU;
			end
			rvPkg::opAuipc:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.aSel     = rvPkg::aPc;
				imm           = immU;
			end
			rvPkg::opReg:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.bSel     = rvPkg::bReg;
				ctrl.aluOp    = aluFromFunct3(funct3, bit30);
				if (funct3[2:1] == 2'b01)
					ctrl.wbSel = rvPkg::wbCompare;
			end
			rvPkg::opImm:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = aluFromFunct3(funct3, bit30 && funct3 == 3'b101);
				if (funct3[2:1] == 2'b01)
					ctrl.wbSel = rvPkg::wbCompare;
				if (funct3[1:0] == 2'b01)
					imm = immShift;                        // SLLI, SRLI, SRAI
			end
			rvPkg::opBranch:
			begin
				ctrl.bSel  = rvPkg::bReg;
				ctrl.aluOp = funct3[1] ? rvPkg::aluSltu : rvPkg::aluSlt;
				imm        = immB;
				case (funct3)
					3'b000:         ctrl.branchOp = rvPkg::brEq;
					3'b001:         ctrl.branchOp = rvPkg::brNe;
					3'b100, 3'b110: ctrl.branchOp = rvPkg::brLt;
					3'b101, 3'b111: ctrl.branchOp = rvPkg::brGe;
					default:        ctrl.branchOp = rvPkg::brNone;
				endcase
			end
			rvPkg::opJal:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.wbSel    = rvPkg::wbPcPlus4;
				ctrl.isJal    = 1'b1;
				imm           = immJ;
			end
			rvPkg::opJalr:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.wbSel    = rvPkg::wbPcPlus4;
				ctrl.isJalr   = 1'b1;                      // Target comes from the ALU
			end
			default:
				imm = immI;
		endcase
	end

endmodule

//--- core/loadStoreUnit.sv
`timescale 1ns/1ps

module loadStoreUnit (
	input  rvPkg::ctrl_t           ctrl,
	input  logic [1:0]             addrLow,
	input  logic [rvPkg::xlen-1:0] storeValue,
	input  logic [rvPkg::xlen-1:0] busData,
	output logic [3:0]             sel,
	output logic [rvPkg::xlen-1:0] storeData,
	output logic [rvPkg::xlen-1:0] loadValue
);

	logic                   isByte;
	logic                   isHalf;
	logic [4:0]             shift;
	logic [rvPkg::xlen-1:0] laneData;

	assign isByte = (ctrl.storeOp == rvPkg::stByte) || (ctrl.loadOp == rvPkg::ldByte) ||
		(ctrl.loadOp == rvPkg::ldByteU);
	assign isHalf = (ctrl.storeOp == rvPkg::stHalf) || (ctrl.loadOp == rvPkg::ldHalf) ||
		(ctrl.loadOp == rvPkg::ldHalfU);
	assign shift  = {addrLow, 3'b000};        // Byte offset in bits

	// Lane selects also apply to loads
	always_comb
	begin
		if (isByte)
		begin
			sel       = 4'b0001 << addrLow;
			storeData = {24'b0, storeValue[7:0]} << shift;
		end
		else if (isHalf)
		begin
			sel       = addrLow[1] ? 4'b1100 : 4'b0011;
			storeData = {16'b0, storeValue[15:0]} << shift;
		end
		else
		begin
			sel       = 4'b1111;
			storeData = storeValue;
		end
	end

	assign laneData = busData >> shift;       // Addressed lane moved to bit 0

	always_comb
	begin
		case (ctrl.loadOp)
			rvPkg::ldByte:  loadValue = {{24{laneData[7]}}, laneData[7:0]};
			rvPkg::ldByteU: loadValue = {24'b0, laneData[7:0]};
			rvPkg::ldHalf:  loadValue = {{16{laneData[15]}}, laneData[15:0]};
			rvPkg::ldHalfU: loadValue = {16'b0, laneData[15:0]};
			default:        loadValue = busData;
		endcase
	end

endmodule

//--- core/regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic [4:0]             rs1,
	input  logic [4:0]             rs2,
	input  logic [4:0]             rd,
	input  logic                   we,
	input  logic [rvPkg::xlen-1:0] wData,
	output logic [rvPkg::xlen-1:0] rData1,
	output logic [rvPkg::xlen-1:0] rData2
);

	logic [rvPkg::xlen-1:0] regs [1:31];   // No storage for x0

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (we && (rd != 5'd0))
			regs[rd] <= wData;
	end

	assign rData1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rData2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- tests/rvCore_checker.sv
`timescale 1ns/1ps

module rvCore_checker (
	input logic          clk,
	input logic          rstN,
	input rvPkg::wbReq_t wbReq,
	input rvPkg::wbRsp_t wbRsp
);

	int failures = 0;

	stbNeedsCyc: assert property (@(posedge clk) disable iff (!rstN)
		wbReq.stb |-> wbReq.cyc)
		else
		begin
			$error("stb high while cyc is low");
			failures++;
		end

	// Master holds the request until ack
	holdPayload: assert property (@(posedge clk) disable iff (!rstN)
		(wbReq.stb && !wbRsp.ack) |=> $stable(wbReq.adr) && $stable(wbReq.datW) &&
		$stable(wbReq.sel) && $stable(wbReq.we))
		else
		begin
			$error("request changed before ack");
			failures++;
		end

	idleAfterReset: assert property (@(posedge clk) !rstN |=> !wbReq.cyc)
		else
		begin
			$error("cyc high in the cycle after reset");
			failures++;
		end

endmodule

bind rvCore rvCore_checker uChecker (.clk(clk), .rstN(rstN), .wbReq(wbReq), .wbRsp(wbRsp));

//--- tests/storeMonitor.sv
`timescale 1ns/1ps

module storeMonitor (
	input  logic          clk,
	input  logic          rstN,
	input  rvPkg::wbReq_t wbReq,
	input  rvPkg::wbRsp_t wbRsp,
	output logic          doneSeen
);

	localparam logic [31:0] doneAdr = 32'h0000_03FC;

	logic [67:0] expected [$];   // {adr, data, sel}
	logic [67:0] item;
	int          errCount;

	initial
	begin
		doneSeen = 1'b0;
		errCount = 0;
	end

	task automatic beginTest();
		expected.delete();
		errCount = 0;
		doneSeen = 1'b0;
	endtask

	task automatic expectStore(input logic [31:0] adr, input logic [31:0] dat,
		input logic [3:0] sel);
		expected.push_back({adr, dat, sel});
	endtask

	task automatic compareField(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		if (exp !== got)
		begin
			$display("Error at %0t ns: %s expected %h got %h", $time, name, exp, got);
			errCount++;
		end
	endtask

	task automatic endTest(input string label, output int errs);
		if (expected.size() != 0)
		begin
			$display("%0d expected stores never appeared on the bus", expected.size());
			errCount++;
		end
		errs = errCount;
		if (errCount == 0)
			$display("%s: ok", label);
		else
			$display("%s: %0d errors", label, errCount);
	endtask

	always @(posedge clk)
	begin
		if (rstN && !doneSeen && wbReq.cyc && wbReq.stb && wbReq.we && wbRsp.ack)
		begin
			if (wbReq.adr == doneAdr)
				doneSeen = 1'b1;
			else if (expected.size() == 0)
			begin
				$display("Unexpected store of %h to address %h at %0t ns",
					wbReq.datW, wbReq.adr, $time);
				errCount++;
			end
			else
			begin
				item = expected.pop_front();
				compareField("wbReq.adr", item[67:36], wbReq.adr);
				compareField("wbReq.datW", item[35:4], wbReq.datW);
				compareField("wbReq.sel", {28'b0, item[3:0]}, {28'b0, wbReq.sel});
			end
		end
	end

endmodule

//--- tests/tbRvCore.sv
`timescale 1ns/1ps

module tbRvCore;

	localparam int numTests      = 5;
	localparam int maxWords      = 64;
	localparam int maxStores     = 32;
	localparam int timeoutCycles = 3000;

	logic          clk;
	logic          rstN;
	logic          randomAck;
	logic          doneSeen;
	rvPkg::wbReq_t wbReq;
	rvPkg::wbRsp_t wbRsp;

	logic [31:0] progMem [numTests][maxWords];
	logic [67:0] expList [numTests][maxStores];   // {adr, data, sel}
	int          progLen [numTests];
	int          expCount [numTests];
	string       testName [numTests];
	int          row;
	int          passCount;
	int          failCount;
	logic        timedOut;

	rvCore DUT (.clk(clk), .rstN(rstN), .wbReq(wbReq), .wbRsp(wbRsp));

	wbMemModel uMem (.clk(clk), .rstN(rstN), .randomAck(randomAck), .wbReq(wbReq),
		.wbRsp(wbRsp));

	storeMonitor uMon (.clk(clk), .rstN(rstN), .wbReq(wbReq), .wbRsp(wbRsp),
		.doneSeen(doneSeen));

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// RV32I instruction encoders
	function automatic logic [31:0] rType(input logic [6:0] f7, input int rs2, input int rs1,
		input logic [2:0] f3, input int rd);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
	endfunction

	function automatic logic [31:0] iType(input int imm, input int rs1, input logic [2:0] f3,
		input int rd, input logic [6:0] op);
		return {12'(imm), 5'(rs1), f3, 5'(rd), op};
	endfunction

	function automatic logic [31:0] sType(input int imm, input int rs2, input int rs1,
		input logic [2:0] f3);
		logic [11:0] i;
		i = 12'(imm);
		return {i[11:5], 5'(rs2), 5'(rs1), f3, i[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] bType(input int imm, input int rs2, input int rs1,
		input logic [2:0] f3);
		logic [12:0] i;
		i = 13'(imm);
		return {i[12], i[10:5], 5'(rs2), 5'(rs1), f3, i[4:1], i[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] uType(input int imm, input int rd, input logic [6:0] op);
		return {20'(imm), 5'(rd), op};
	endfunction

	function automatic logic [31:0] jType(input int imm, input int rd);
		logic [20:0] i;
		i = 21'(imm);
		return {i[20], i[10:1], i[11], i[19:12], 5'(rd), 7'b1101111};
	endfunction

	function automatic logic [31:0] here();
		return 32'(progLen[row] * 4);
	endfunction

	task automatic emit(input logic [31:0] w);
		progMem[row][progLen[row]] = w;
		progLen[row]++;
	endtask

	task automatic expectStore(input logic [31:0] adr, input logic [31:0] dat,
		input logic [3:0] sel);
		expList[row][expCount[row]] = {adr, dat, sel};
		expCount[row]++;
	endtask

	// Word store of rs into the next result slot
	task automatic storeNext(input int rs, input logic [31:0] value);
		emit(sType(expCount[row] * 4, rs, 31, 3'b010));
		expectStore(32'h200 + 32'(expCount[row] * 4), value, 4'hF);
	endtask

	task automatic startRow(input string name);
		row++;
		testName[row] = name;
		progLen[row]  = 0;
		expCount[row] = 0;
		emit(iType(32'h200, 0, 3'b000, 31, rvPkg::opImm));   // x31 = result area
	endtask

	task automatic endRow();
		emit(iType(32'h3FC, 0, 3'b000, 30, rvPkg::opImm));
		emit(sType(0, 0, 30, 3'b010));                         // Done marker
	endtask

	task automatic loadCheck(input logic [2:0] f3, input int off, input logic [31:0] value);
		emit(iType(off, 5, f3, 3, rvPkg::opLoad));
		storeNext(3, value);
	endtask

	task automatic laneStore(input logic [2:0] f3, input int off, input logic [31:0] dat,
		input logic [3:0] sel);
		emit(sType(off, 1, 31, f3));
		expectStore(32'h200 + 32'(off), dat, sel);
	endtask

	// Marker k if taken, k + 1 if the fall-through add runs
	task automatic branchCase(input logic [2:0] f3, input int rs1, input int rs2,
		input logic taken);
		int k;
		k = 16 * (expCount[row] + 1);
		emit(iType(k, 0, 3'b000, 3, rvPkg::opImm));
		emit(bType(8, rs2, rs1, f3));
		emit(iType(1, 3, 3'b000, 3, rvPkg::opImm));
		storeNext(3, taken ? 32'(k) : 32'(k + 1));
	endtask

	task automatic buildTable();
		logic [31:0] a;
		row = -1;
		startRow("alu and immediates");
		emit(iType(-7, 0, 3'b000, 1, rvPkg::opImm));
		emit(iType(3, 0, 3'b000, 2, rvPkg::opImm));
		emit(rType(7'h00, 2, 1, 3'b000, 3));
		storeNext(3, 32'hFFFF_FFFC);
		emit(rType(7'h20, 2, 1, 3'b000, 3));
		storeNext(3, 32'hFFFF_FFF6);
		emit(rType(7'h00, 2, 1, 3'b100, 3));
		storeNext(3, 32'hFFFF_FFFA);
		emit(rType(7'h00, 2, 1, 3'b110, 3));
		storeNext(3, 32'hFFFF_FFFB);
		emit(rType(7'h00, 2, 1, 3'b111, 3));
		storeNext(3, 32'h0000_0001);
		emit(rType(7'h00, 2, 1, 3'b001, 3));
		storeNext(3, 32'hFFFF_FFC8);
		emit(rType(7'h00, 2, 1, 3'b101, 3));
		storeNext(3, 32'h1FFF_FFFF);
		emit(rType(7'h20, 2, 1, 3'b101, 3));
		storeNext(3, 32'hFFFF_FFFF);
		emit(rType(7'h00, 2, 1, 3'b010, 3));
		storeNext(3, 32'h0000_0001);
		emit(rType(7'h00, 2, 1, 3'b011, 3));
		storeNext(3, 32'h0000_0000);
		emit(iType(-1, 2, 3'b011, 3, rvPkg::opImm));          // SLTIU
		storeNext(3, 32'h0000_0001);
		emit(iType(32'h401, 1, 3'b101, 3, rvPkg::opImm));     // SRAI by 1
		storeNext(3, 32'hFFFF_FFFC);
		emit(iType(32'h7F0, 2, 3'b100, 3, rvPkg::opImm));
		storeNext(3, 32'h0000_07F3);
		emit(iType(32'h0F0, 1, 3'b111, 3, rvPkg::opImm));
		storeNext(3, 32'h0000_00F0);
		emit(iType(30, 2, 3'b001, 3, rvPkg::opImm));
		storeNext(3, 32'hC000_0000);
		emit(iType(28, 1, 3'b101, 3, rvPkg::opImm));
		storeNext(3, 32'h0000_000F);
		emit(uType(32'h12345, 3, rvPkg::opLui));
		storeNext(3, 32'h1234_5000);
		a = here();
		emit(uType(1, 3, rvPkg::opAuipc));
		storeNext(3, a + 32'h1000);
		emit(32'h0000_01FF);                                 // Unknown opcode with rd = x3
		storeNext(3, a + 32'h1000);
		endRow();

		startRow("loads");
		emit(iType(32'h100, 0, 3'b000, 5, rvPkg::opImm));
		loadCheck(3'b000, 0, 32'hFFFF_FF82);
		loadCheck(3'b000, 1, 32'h0000_007F);
		loadCheck(3'b000, 2, 32'hFFFF_FFF1);
		loadCheck(3'b000, 3, 32'hFFFF_FF80);
		loadCheck(3'b100, 3, 32'h0000_0080);
		loadCheck(3'b100, 0, 32'h0000_0082);
		loadCheck(3'b001, 0, 32'h0000_7F82);
		loadCheck(3'b001, 2, 32'hFFFF_80F1);
		loadCheck(3'b101, 2, 32'h0000_80F1);
		loadCheck(3'b010, 0, 32'h80F1_7F82);
		endRow();

		startRow("store lanes");
		emit(uType(32'hA1B2C, 1, rvPkg::opLui));
		emit(iType(32'h3D4, 1, 3'b000, 1, rvPkg::opImm));
		laneStore(3'b000, 0, 32'h0000_00D4, 4'b0001);
		laneStore(3'b000, 1, 32'h0000_D400, 4'b0010);
		laneStore(3'b000, 2, 32'h00D4_0000, 4'b0100);
		laneStore(3'b000, 3, 32'hD400_0000, 4'b1000);
		laneStore(3'b001, 4, 32'h0000_C3D4, 4'b0011);
		laneStore(3'b001, 6, 32'hC3D4_0000, 4'b1100);
		laneStore(3'b010, 8, 32'hA1B2_C3D4, 4'b1111);
		endRow();

		startRow("branches");
		emit(iType(-1, 0, 3'b000, 1, rvPkg::opImm));
		emit(iType(1, 0, 3'b000, 2, rvPkg::opImm));
		branchCase(3'b000, 1, 1, 1'b1);
		branchCase(3'b000, 1, 2, 1'b0);
		branchCase(3'b001, 1, 2, 1'b1);
		branchCase(3'b001, 1, 1, 1'b0);
		branchCase(3'b100, 1, 2, 1'b1);
		branchCase(3'b100, 2, 1, 1'b0);
		branchCase(3'b101, 2, 1, 1'b1);
		branchCase(3'b101, 1, 2, 1'b0);
		branchCase(3'b110, 2, 1, 1'b1);
		branchCase(3'b110, 1, 2, 1'b0);
		branchCase(3'b111, 1, 2, 1'b1);
		branchCase(3'b111, 2, 1, 1'b0);
		endRow();

		startRow("jumps");
		emit(iType(-1, 0, 3'b000, 6, rvPkg::opImm));
		a = here();
		emit(jType(12, 4));
		emit(sType(64, 6, 31, 3'b010));                       // Skipped by JAL
		emit(sType(64, 6, 31, 3'b010));
		storeNext(4, a + 32'd4);
		a = here();
		emit(uType(0, 7, rvPkg::opAuipc));
		emit(iType(13, 7, 3'b000, 8, rvPkg::opJalr));         // Odd target loses bit 0
		emit(sType(64, 6, 31, 3'b010));
		emit(uType(0, 9, rvPkg::opAuipc));                    // Captures the landing PC
		storeNext(8, a + 32'd8);
		storeNext(9, a + 32'd12);
		endRow();
	endtask

	task automatic runTest(input int r, input string mode);
		int cycles;
		int errs;
		@(posedge clk);
		#1 rstN = 1'b0;
		@(posedge clk);
		#1;
		uMem.fill();
		for (int i = 0; i < progLen[r]; i++)
			uMem.writeWord(i, progMem[r][i]);
		uMem.writeWord(64, 32'h80F1_7F82);                   // Load data at 0x100
		uMon.beginTest();
		for (int e = 0; e < expCount[r]; e++)
			uMon.expectStore(expList[r][e][67:36], expList[r][e][35:4], expList[r][e][3:0]);
		@(posedge clk);
		#1 rstN = 1'b1;
		cycles = 0;
		while (!doneSeen && cycles < timeoutCycles)
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!doneSeen)
		begin
			$display("Timeout: no store to the done address within %0d cycles", timeoutCycles);
			timedOut = 1'b1;
		end
		uMon.endTest({testName[r], ", ", mode}, errs);
		if (errs != 0 || !doneSeen)
			failCount++;
		else
			passCount++;
	endtask

	initial
	begin
		rstN      = 1'b0;
		randomAck = 1'b0;
		passCount = 0;
		failCount = 0;
		timedOut  = 1'b0;
		buildTable();
		for (int r = 0; r < numTests; r++)
			runTest(r, "no wait states");
		randomAck = 1'b1;
		for (int r = 0; r < numTests; r++)
			runTest(r, "random wait states");
		if (DUT.uChecker.failures != 0)
			$display("%0d Wishbone protocol assertions failed", DUT.uChecker.failures);
		$display("Summary: %0d passing, %0d failing", passCount, failCount);
		if (failCount == 0 && !timedOut && DUT.uChecker.failures == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- tests/wbMemModel.sv
`timescale 1ns/1ps

module wbMemModel (
	input  logic          clk,
	input  logic          rstN,
	input  logic          randomAck,
	input  rvPkg::wbReq_t wbReq,
	output rvPkg::wbRsp_t wbRsp
);

	logic [31:0] mem [0:255];   // 1 KiB, word indexed
	logic [31:0] lcgState;
	int          waitLeft;

	function automatic logic [31:0] nextRandom(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic fill();
		for (int i = 0; i < 256; i++)
			mem[i] = {~i[15:0], i[15:0]};   // Pattern from the whole word address
	endtask

	task automatic writeWord(input int idx, input logic [31:0] w);
		mem[idx] = w;
	endtask

	initial
	begin
		wbRsp    = '0;
		waitLeft = -1;
		lcgState = 32'h58b7_b845;
	end

	// Responses change a small delay after the rising edge
	always @(posedge clk)
	begin
		#1;
		if (!rstN)
		begin
			wbRsp.ack = 1'b0;
			waitLeft  = -1;
		end
		else if (wbRsp.ack)
			wbRsp.ack = 1'b0;                  // One-cycle ack
		else if (wbReq.cyc && wbReq.stb)
		begin
			if (waitLeft < 0)
			begin
				lcgState = nextRandom(lcgState);
				waitLeft = randomAck ? int'(lcgState[17:16]) : 0;
			end
			if (waitLeft == 0)
			begin
				if (wbReq.we)
				begin
					for (int b = 0; b < 4; b++)
						if (wbReq.sel[b])
							mem[wbReq.adr[9:2]][8*b +: 8] = wbReq.datW[8*b +: 8];
				end
				wbRsp.datR = mem[wbReq.adr[9:2]];
				wbRsp.ack  = 1'b1;
				waitLeft   = -1;
			end
			else
				waitLeft--;
		end
	end

endmodule

//--- verilog/rvCore.sv
`timescale 1ns/1ps

module rvCore (
	input  logic          clk,
	input  logic          rstN,
	output rvPkg::wbReq_t wbReq,
	input  rvPkg::wbRsp_t wbRsp
);

	rvPkg::ctrl_t           ctrl;
	logic [rvPkg::xlen-1:0] instr;
	logic [rvPkg::xlen-1:0] imm;
	logic [rvPkg::xlen-1:0] opA;
	logic [rvPkg::xlen-1:0] opB;
	logic [rvPkg::xlen-1:0] aluResult;
	logic [rvPkg::xlen-1:0] rData1;
	logic [rvPkg::xlen-1:0] rData2;
	logic [rvPkg::xlen-1:0] wData;
	logic [rvPkg::xlen-1:0] storeData;
	logic [rvPkg::xlen-1:0] loadValue;
	logic                   eq;
	logic                   lt;
	logic                   regWe;
	logic [3:0]             lsuSel;
	logic [4:0]             rs1;
	logic [4:0]             rs2;
	logic [4:0]             rd;

	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd  = instr[11:7];

	coreControl uControl (
		.clk(clk), .rstN(rstN), .ctrl(ctrl), .imm(imm), .eq(eq), .lt(lt),
		.aluResult(aluResult), .rData1(rData1), .rData2(rData2),
		.lsuSel(lsuSel), .storeData(storeData), .loadValue(loadValue),
		.instr(instr), .opA(opA), .opB(opB), .regWe(regWe), .wData(wData),
		.wbReq(wbReq), .wbRsp(wbRsp)
	);

	instrDecode uDecode (.instr(instr), .ctrl(ctrl), .imm(imm));

	aluUnit uAlu (.ctrl(ctrl), .opA(opA), .opB(opB), .result(aluResult), .eq(eq), .lt(lt));

	regFile uRegs (
		.clk(clk), .rstN(rstN), .rs1(rs1), .rs2(rs2), .rd(rd), .we(regWe),
		.wData(wData), .rData1(rData1), .rData2(rData2)
	);

	// ALU result is the data address and holds through the memory state
	loadStoreUnit uLsu (
		.ctrl(ctrl), .addrLow(aluResult[1:0]), .storeValue(rData2), .busData(wbRsp.datR),
		.sel(lsuSel), .storeData(storeData), .loadValue(loadValue)
	);

endmodule
